/* core_top.sv */
module core_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        instr_v_i,
  input  pipe_pkg::instr_t            instr_i,
  output logic                        instr_ready_o,
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  output logic [pipe_pkg::DATA_W-1:0] wb_adr_o,
  output logic [pipe_pkg::DATA_W-1:0] wb_dat_o,
  input  logic [pipe_pkg::DATA_W-1:0] wb_dat_i,
  input  logic                        wb_ack_i
);

  logic [pipe_pkg::REG_AW-1:0]      rs1_addr, rs2_addr;
  logic [pipe_pkg::DATA_W-1:0]      rs1_data, rs2_data;
  logic [1:0][pipe_pkg::REG_AW-1:0] sb_src_id;
  logic [1:0]                       sb_op_reads;
  logic [pipe_pkg::REG_AW-1:0]      sb_dest_id;
  logic                             sb_op_writes, dependency;
  logic                             mem_busy, mul_busy;
  logic                             score_v;
  logic [pipe_pkg::REG_AW-1:0]      score_id;
  logic                             alu_wr_v, ld_wr_v, mul_wr_v;
  logic [pipe_pkg::REG_AW-1:0]      alu_wr_addr, ld_wr_addr, mul_wr_addr;
  logic [pipe_pkg::DATA_W-1:0]      alu_wr_data, ld_wr_data, mul_wr_data;
  logic                             mem_req_v, mem_we, mul_req_v;
  logic [pipe_pkg::DATA_W-1:0]      mem_adr, mem_dat, mul_a, mul_b;
  logic [pipe_pkg::REG_AW-1:0]      mem_rd, mul_rd;

  issue_if iss ();

  decode_stage dec (
    .clk_i, .reset_i, .instr_v_i, .instr_i, .instr_ready_o,
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .sb_src_id_o(sb_src_id), .sb_op_reads_o(sb_op_reads),
    .sb_dest_id_o(sb_dest_id), .sb_op_writes_o(sb_op_writes),
    .dependency_i(dependency), .mem_busy_i(mem_busy), .mul_busy_i(mul_busy),
    .iss(iss.decode_mp)
  );

  execute_stage exe (
    .clk_i, .reset_i, .iss(iss.execute_mp),
    .alu_wr_v_o(alu_wr_v), .alu_wr_addr_o(alu_wr_addr), .alu_wr_data_o(alu_wr_data),
    .score_v_o(score_v), .score_id_o(score_id),
    .mem_req_v_o(mem_req_v), .mem_we_o(mem_we), .mem_adr_o(mem_adr),
    .mem_dat_o(mem_dat), .mem_rd_o(mem_rd),
    .mul_req_v_o(mul_req_v), .mul_a_o(mul_a), .mul_b_o(mul_b), .mul_rd_o(mul_rd),
    .mem_busy_i(mem_busy), .mul_busy_i(mul_busy)
  );

  mem_unit mem (
    .clk_i, .reset_i, .req_v_i(mem_req_v), .we_i(mem_we), .adr_i(mem_adr),
    .dat_i(mem_dat), .rd_i(mem_rd), .busy_o(mem_busy),
    .wb_cyc_o, .wb_stb_o, .wb_we_o, .wb_adr_o, .wb_dat_o, .wb_dat_i, .wb_ack_i,
    .ld_wr_v_o(ld_wr_v), .ld_wr_addr_o(ld_wr_addr), .ld_wr_data_o(ld_wr_data)
  );

  mul_unit mul (
    .clk_i, .reset_i, .req_v_i(mul_req_v), .a_i(mul_a), .b_i(mul_b), .rd_i(mul_rd),
    .busy_o(mul_busy),
    .mul_wr_v_o(mul_wr_v), .mul_wr_addr_o(mul_wr_addr), .mul_wr_data_o(mul_wr_data)
  );

  regfile rf (
    .clk_i, .reset_i,
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .alu_v_i(alu_wr_v), .alu_addr_i(alu_wr_addr), .alu_data_i(alu_wr_data),
    .ld_v_i(ld_wr_v), .ld_addr_i(ld_wr_addr), .ld_data_i(ld_wr_data),
    .mul_v_i(mul_wr_v), .mul_addr_i(mul_wr_addr), .mul_data_i(mul_wr_data)
  );

  // every writeback source clears its own destination
  scoreboard #(.num_clear_p(3)) sb (
    .clk_i, .reset_i,
    .src_id_i(sb_src_id), .op_reads_i(sb_op_reads),
    .dest_id_i(sb_dest_id), .op_writes_i(sb_op_writes),
    .score_i(score_v), .score_id_i(score_id),
    .clear_i({mul_wr_v, ld_wr_v, alu_wr_v}),
    .clear_id_i({mul_wr_addr, ld_wr_addr, alu_wr_addr}),
    .dependency_o(dependency)
  );

endmodule

/* decode_stage.sv */
module decode_stage (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             instr_v_i,
  input  pipe_pkg::instr_t                 instr_i,
  output logic                             instr_ready_o,
  output logic [pipe_pkg::REG_AW-1:0]      rs1_addr_o,
  output logic [pipe_pkg::REG_AW-1:0]      rs2_addr_o,
  input  logic [pipe_pkg::DATA_W-1:0]      rs1_data_i,
  input  logic [pipe_pkg::DATA_W-1:0]      rs2_data_i,
  output logic [1:0][pipe_pkg::REG_AW-1:0] sb_src_id_o,
  output logic [1:0]                       sb_op_reads_o,
  output logic [pipe_pkg::REG_AW-1:0]      sb_dest_id_o,
  output logic                             sb_op_writes_o,
  input  logic                             dependency_i,
  input  logic                             mem_busy_i,
  input  logic                             mul_busy_i,
  issue_if.decode_mp                       iss
);

  pipe_pkg::instr_t instr_r;
  logic             valid_r;
  logic             is_mem;
  logic             is_mul;
  logic             issue;
  // execute holds a unit request for a cycle before the unit shows busy
  logic             mem_iss_r;
  logic             mul_iss_r;

  assign is_mem = (instr_r.op == pipe_pkg::OP_LD) || (instr_r.op == pipe_pkg::OP_ST);
  assign is_mul = (instr_r.op == pipe_pkg::OP_MUL);

  // operand usage per opcode
  always_comb begin
    sb_op_reads_o  = 2'b00;
    sb_op_writes_o = 1'b0;
    case (instr_r.op)
      pipe_pkg::OP_ADD,
      pipe_pkg::OP_MUL: begin
        sb_op_reads_o  = 2'b11;
        sb_op_writes_o = 1'b1;
      end
      pipe_pkg::OP_ADDI,
      pipe_pkg::OP_LD: begin
        sb_op_reads_o  = 2'b01;
        sb_op_writes_o = 1'b1;
      end
      pipe_pkg::OP_ST: sb_op_reads_o = 2'b11;
      default: ;
    endcase
    sb_op_reads_o  = sb_op_reads_o & {2{valid_r}};
    sb_op_writes_o = sb_op_writes_o & valid_r;
  end

  assign sb_src_id_o  = {instr_r.rs2, instr_r.rs1};
  assign sb_dest_id_o = instr_r.rd;
  assign rs1_addr_o   = instr_r.rs1;
  assign rs2_addr_o   = instr_r.rs2;

  assign issue = valid_r && !dependency_i
              && !(is_mem && (mem_busy_i || mem_iss_r))
              && !(is_mul && (mul_busy_i || mul_iss_r));

  assign instr_ready_o = !valid_r || issue;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r   <= 1'b0;
      mem_iss_r <= 1'b0;
      mul_iss_r <= 1'b0;
    end else begin
      if (instr_ready_o) valid_r <= instr_v_i;
      mem_iss_r <= issue && is_mem;
      mul_iss_r <= issue && is_mul;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_v_i && instr_ready_o) instr_r <= instr_i;
  end

  assign iss.v       = issue;
  assign iss.op      = instr_r.op;
  assign iss.rd      = instr_r.rd;
  assign iss.rs1_val = rs1_data_i;
  assign iss.rs2_val = rs2_data_i;
  assign iss.imm     = instr_r.rs2;

endmodule

/* execute_stage.sv */
module execute_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,
  issue_if.execute_mp                 iss,
  output logic                        alu_wr_v_o,
  output logic [pipe_pkg::REG_AW-1:0] alu_wr_addr_o,
  output logic [pipe_pkg::DATA_W-1:0] alu_wr_data_o,
  output logic                        score_v_o,
  output logic [pipe_pkg::REG_AW-1:0] score_id_o,
  output logic                        mem_req_v_o,
  output logic                        mem_we_o,
  output logic [pipe_pkg::DATA_W-1:0] mem_adr_o,
  output logic [pipe_pkg::DATA_W-1:0] mem_dat_o,
  output logic [pipe_pkg::REG_AW-1:0] mem_rd_o,
  output logic                        mul_req_v_o,
  output logic [pipe_pkg::DATA_W-1:0] mul_a_o,
  output logic [pipe_pkg::DATA_W-1:0] mul_b_o,
  output logic [pipe_pkg::REG_AW-1:0] mul_rd_o,
  input  logic                        mem_busy_i,
  input  logic                        mul_busy_i
);

  logic                        ex_v_r;
  pipe_pkg::opcode_e           op_r;
  logic [pipe_pkg::REG_AW-1:0] rd_r;
  logic [pipe_pkg::DATA_W-1:0] a_r;
  logic [pipe_pkg::DATA_W-1:0] b_r;
  logic [pipe_pkg::REG_AW-1:0] imm_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_v_r <= 1'b0;
    end else begin
      ex_v_r <= iss.v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (iss.v) begin
      op_r  <= iss.op;
      rd_r  <= iss.rd;
      a_r   <= iss.rs1_val;
      b_r   <= iss.rs2_val;
      imm_r <= iss.imm;
    end
  end

  // single-cycle adder, addi zero-extends its immediate
  assign alu_wr_v_o    = ex_v_r && (op_r == pipe_pkg::OP_ADD || op_r == pipe_pkg::OP_ADDI);
  assign alu_wr_addr_o = rd_r;
  assign alu_wr_data_o = a_r + ((op_r == pipe_pkg::OP_ADDI) ? pipe_pkg::DATA_W'(imm_r) : b_r);

  // long-latency destinations are marked pending as they leave
  assign score_v_o  = ex_v_r && (op_r == pipe_pkg::OP_LD || op_r == pipe_pkg::OP_MUL);
  assign score_id_o = rd_r;

  assign mem_req_v_o = ex_v_r && (op_r == pipe_pkg::OP_LD || op_r == pipe_pkg::OP_ST);
  assign mem_we_o    = (op_r == pipe_pkg::OP_ST);
  assign mem_adr_o   = a_r;
  assign mem_dat_o   = b_r;
  assign mem_rd_o    = rd_r;

  assign mul_req_v_o = ex_v_r && (op_r == pipe_pkg::OP_MUL);
  assign mul_a_o     = a_r;
  assign mul_b_o     = b_r;
  assign mul_rd_o    = rd_r;

  // decode's unit check must cover the cycle spent here
  assert property (@(posedge clk_i) disable iff (reset_i)
    !(mem_req_v_o && mem_busy_i) && !(mul_req_v_o && mul_busy_i))
    else $error("unit started while busy");

endmodule

/* issue_if.sv */
interface issue_if;

  logic                        v;
  pipe_pkg::opcode_e           op;
  logic [pipe_pkg::REG_AW-1:0] rd;
  logic [pipe_pkg::DATA_W-1:0] rs1_val;
  logic [pipe_pkg::DATA_W-1:0] rs2_val;
  logic [pipe_pkg::REG_AW-1:0] imm;

  // execute completes every issue in one cycle, so there is no ready
  modport decode_mp (
    output v, op, rd, rs1_val, rs2_val, imm
  );

  modport execute_mp (
    input v, op, rd, rs1_val, rs2_val, imm
  );

endinterface

/* mem_unit.sv */
module mem_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        req_v_i,
  input  logic                        we_i,
  input  logic [pipe_pkg::DATA_W-1:0] adr_i,
  input  logic [pipe_pkg::DATA_W-1:0] dat_i,
  input  logic [pipe_pkg::REG_AW-1:0] rd_i,
  output logic                        busy_o,
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  output logic [pipe_pkg::DATA_W-1:0] wb_adr_o,
  output logic [pipe_pkg::DATA_W-1:0] wb_dat_o,
  input  logic [pipe_pkg::DATA_W-1:0] wb_dat_i,
  input  logic                        wb_ack_i,
  output logic                        ld_wr_v_o,
  output logic [pipe_pkg::REG_AW-1:0] ld_wr_addr_o,
  output logic [pipe_pkg::DATA_W-1:0] ld_wr_data_o
);

  logic                        cyc_r;
  logic                        we_r;
  logic [pipe_pkg::DATA_W-1:0] adr_r;
  logic [pipe_pkg::DATA_W-1:0] dat_r;
  logic [pipe_pkg::REG_AW-1:0] rd_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cyc_r <= 1'b0;
    end else if (cyc_r && wb_ack_i) begin
      cyc_r <= 1'b0;
    end else if (req_v_i) begin
      cyc_r <= 1'b1;
    end
  end

  // request fields are captured only when starting a cycle
  always_ff @(posedge clk_i) begin
    if (req_v_i && !cyc_r) begin
      we_r  <= we_i;
      adr_r <= adr_i;
      dat_r <= dat_i;
      rd_r  <= rd_i;
    end
  end

  assign wb_cyc_o = cyc_r;
  assign wb_stb_o = cyc_r;
  assign wb_we_o  = we_r;
  assign wb_adr_o = adr_r;
  assign wb_dat_o = dat_r;

  // busy ends in the ack cycle and cyc drops at the next edge
  assign busy_o = cyc_r && !wb_ack_i;

  // load data goes straight to the register file on ack
  assign ld_wr_v_o    = cyc_r && wb_ack_i && !we_r;
  assign ld_wr_addr_o = rd_r;
  assign ld_wr_data_o = wb_dat_i;

  // a request arriving during an open cycle would be lost
  assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i |-> !cyc_r)
    else $error("request arrived while a wishbone cycle is open");

endmodule

/* mul_unit.sv */
module mul_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        req_v_i,
  input  logic [pipe_pkg::DATA_W-1:0] a_i,
  input  logic [pipe_pkg::DATA_W-1:0] b_i,
  input  logic [pipe_pkg::REG_AW-1:0] rd_i,
  output logic                        busy_o,
  output logic                        mul_wr_v_o,
  output logic [pipe_pkg::REG_AW-1:0] mul_wr_addr_o,
  output logic [pipe_pkg::DATA_W-1:0] mul_wr_data_o
);

  localparam int CNT_W = $clog2(pipe_pkg::MUL_CYCLES);

  logic                        busy_r;
  logic [CNT_W-1:0]            cnt_r;
  logic                        last;
  logic [pipe_pkg::DATA_W-1:0] acc_r;
  logic [pipe_pkg::DATA_W-1:0] a_r;
  logic [pipe_pkg::DATA_W-1:0] b_r;
  logic [pipe_pkg::REG_AW-1:0] rd_r;
  logic [pipe_pkg::DATA_W-1:0] acc_next;

  assign last     = busy_r && (cnt_r == CNT_W'(pipe_pkg::MUL_CYCLES - 1));
  // add the shifted multiplicand for each set multiplier bit
  assign acc_next = acc_r + (b_r[0] ? a_r : '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
    end else if (req_v_i) begin
      busy_r <= 1'b1;
      cnt_r  <= '0;
    end else if (busy_r) begin
      busy_r <= !last;
      cnt_r  <= cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      acc_r <= '0;
      a_r   <= a_i;
      b_r   <= b_i;
      rd_r  <= rd_i;
    end else if (busy_r) begin
      acc_r <= acc_next;
      a_r   <= a_r << 1;
      b_r   <= b_r >> 1;
    end
  end

  // the final iteration's sum is written back directly
  assign busy_o        = busy_r && !last;
  assign mul_wr_v_o    = last;
  assign mul_wr_addr_o = rd_r;
  assign mul_wr_data_o = acc_next;

endmodule

/* pipe_pkg.sv */
package pipe_pkg;

  // architectural register file
  localparam int REG_ELS = 16;
  localparam int REG_AW  = 4;

  // data and address width
  localparam int DATA_W = 16;

  // one multiplier bit per iteration
  localparam int MUL_CYCLES = 16;

  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_ADDI = 4'd2,
    OP_LD   = 4'd3,
    OP_ST   = 4'd4,
    OP_MUL  = 4'd5
  } opcode_e;

  // rs2 doubles as the 4-bit immediate of addi
  typedef struct packed {
    opcode_e           op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
  } instr_t;

endpackage

/* regfile.sv */
module regfile (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [pipe_pkg::REG_AW-1:0] rs1_addr_i,
  input  logic [pipe_pkg::REG_AW-1:0] rs2_addr_i,
  output logic [pipe_pkg::DATA_W-1:0] rs1_data_o,
  output logic [pipe_pkg::DATA_W-1:0] rs2_data_o,
  input  logic                        alu_v_i,
  input  logic [pipe_pkg::REG_AW-1:0] alu_addr_i,
  input  logic [pipe_pkg::DATA_W-1:0] alu_data_i,
  input  logic                        ld_v_i,
  input  logic [pipe_pkg::REG_AW-1:0] ld_addr_i,
  input  logic [pipe_pkg::DATA_W-1:0] ld_data_i,
  input  logic                        mul_v_i,
  input  logic [pipe_pkg::REG_AW-1:0] mul_addr_i,
  input  logic [pipe_pkg::DATA_W-1:0] mul_data_i
);

  logic [pipe_pkg::REG_ELS-1:0][pipe_pkg::DATA_W-1:0] regs_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      regs_r <= '0;
    end else begin
      if (alu_v_i) regs_r[alu_addr_i] <= alu_data_i;
      if (ld_v_i) regs_r[ld_addr_i] <= ld_data_i;
      if (mul_v_i) regs_r[mul_addr_i] <= mul_data_i;
    end
  end

  // write-through, a register written this cycle reads its new value
  always_comb begin
    rs1_data_o = regs_r[rs1_addr_i];
    if (alu_v_i && alu_addr_i == rs1_addr_i) rs1_data_o = alu_data_i;
    if (ld_v_i && ld_addr_i == rs1_addr_i) rs1_data_o = ld_data_i;
    if (mul_v_i && mul_addr_i == rs1_addr_i) rs1_data_o = mul_data_i;
  end

  always_comb begin
    rs2_data_o = regs_r[rs2_addr_i];
    if (alu_v_i && alu_addr_i == rs2_addr_i) rs2_data_o = alu_data_i;
    if (ld_v_i && ld_addr_i == rs2_addr_i) rs2_data_o = ld_data_i;
    if (mul_v_i && mul_addr_i == rs2_addr_i) rs2_data_o = mul_data_i;
  end

  // the scoreboard keeps writebacks to one register apart in time
  assert property (@(posedge clk_i) disable iff (reset_i)
    !((alu_v_i && ld_v_i && alu_addr_i == ld_addr_i)
      || (alu_v_i && mul_v_i && alu_addr_i == mul_addr_i)
      || (ld_v_i && mul_v_i && ld_addr_i == mul_addr_i)))
    else $error("two write ports target the same register");

endmodule

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f vlog.f --top-module tb_core_top -o sim_core

./obj_dir/sim_core > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0

/* scoreboard.sv */
module scoreboard #(
  parameter int num_clear_p = 3
) (
  input  logic                                         clk_i,
  input  logic                                         reset_i,
  input  logic [1:0][pipe_pkg::REG_AW-1:0]             src_id_i,
  input  logic [1:0]                                   op_reads_i,
  input  logic [pipe_pkg::REG_AW-1:0]                  dest_id_i,
  input  logic                                         op_writes_i,
  input  logic                                         score_i,
  input  logic [pipe_pkg::REG_AW-1:0]                  score_id_i,
  input  logic [num_clear_p-1:0]                       clear_i,
  input  logic [num_clear_p-1:0][pipe_pkg::REG_AW-1:0] clear_id_i,
  output logic                                         dependency_o
);

  logic [pipe_pkg::REG_ELS-1:0] pending_r;
  logic [pipe_pkg::REG_ELS-1:0] score_mask;
  logic [pipe_pkg::REG_ELS-1:0] clear_mask;
  logic [1:0]                   src_busy;
  logic [1:0]                   src_on_score;
  logic                         dest_busy;
  logic                         dest_on_score;

  // one-hot masks of the registers scored and cleared this cycle
  always_comb begin
    score_mask = '0;
    clear_mask = '0;
    if (score_i) begin
      score_mask[score_id_i] = 1'b1;
    end
    for (int j = 0; j < num_clear_p; j++) begin
      if (clear_i[j]) begin
        clear_mask[clear_id_i[j]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_r <= '0;
    end else begin
      pending_r <= (pending_r & ~clear_mask) | score_mask;
    end
  end

  // a bit being cleared now no longer blocks, its value is written through
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      src_busy[i]     = op_reads_i[i] & pending_r[src_id_i[i]] & ~clear_mask[src_id_i[i]];
      src_on_score[i] = op_reads_i[i] & (src_id_i[i] == score_id_i);
    end
    dest_busy     = op_writes_i & pending_r[dest_id_i] & ~clear_mask[dest_id_i];
    dest_on_score = op_writes_i & (dest_id_i == score_id_i);
  end

  // the register scored in execute this cycle blocks decode too
  assign dependency_o = (|src_busy) | dest_busy
                      | (score_i & ((|src_on_score) | dest_on_score));

  // decode must never let a new score overlap an outstanding writeback
  assert property (@(posedge clk_i) disable iff (reset_i)
    (score_mask & clear_mask) == '0)
    else $error("score and clear hit the same register");

endmodule

/* tb_core_top.sv */
module tb_core_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [15:0] RD_XOR    = 16'hA5C3;
  localparam int unsigned SEED      = 32'h853bad68;
  localparam int          ACCEPT_TO = 300;
  localparam int          DRAIN_TO  = 2000;
  localparam int          RAND_LEN  = 200;

  logic             clk;
  logic             reset;
  logic             instr_v;
  pipe_pkg::instr_t instr;
  logic             instr_ready;
  logic             wb_cyc, wb_stb, wb_we, wb_ack;
  logic [15:0]      wb_adr, wb_dat_w, wb_dat_r;
  logic             st_v;
  int               st_cnt;

  // in-order reference state
  logic [15:0] model_rf [pipe_pkg::REG_ELS];
  logic [31:0] exp_q [$];
  logic        exp_avail = 1'b0;
  logic [15:0] exp_adr, exp_dat;
  logic        mem_seen = 1'b0;
  logic [32:0] held_req;
  int          stores_sent = 0;
  int          data_errs = 0;
  int          proto_errs = 0;
  int          timeouts = 0;
  bit          hung = 1'b0;

  core_top uut (
    .clk_i(clk), .reset_i(reset), .instr_v_i(instr_v), .instr_i(instr),
    .instr_ready_o(instr_ready), .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we),
    .wb_adr_o(wb_adr), .wb_dat_o(wb_dat_w), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack)
  );

  tb_wb_mem #(.rd_xor_p(RD_XOR)) mem (
    .clk_i(clk), .reset_i(reset), .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
    .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
    .st_cnt_o(st_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  assign st_v = wb_cyc & wb_we & wb_ack;

  always @(posedge clk) held_req <= {wb_we, wb_adr, wb_dat_w};

  always @(posedge clk) begin : ref_model
    logic [31:0] prod;
    if (reset) begin
      for (int i = 0; i < pipe_pkg::REG_ELS; i++) begin
        model_rf[i] = '0;
      end
      exp_q.delete();
      exp_avail <= 1'b0;
      mem_seen  <= 1'b0;
    end else begin
      if (st_v && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (instr_v && instr_ready) begin
        case (instr.op)
          pipe_pkg::OP_ADD:  model_rf[instr.rd] = model_rf[instr.rs1] + model_rf[instr.rs2];
          pipe_pkg::OP_ADDI: model_rf[instr.rd] = model_rf[instr.rs1] + {12'h000, instr.rs2};
          pipe_pkg::OP_LD:   model_rf[instr.rd] = model_rf[instr.rs1] ^ RD_XOR;
          pipe_pkg::OP_ST: begin
            exp_q.push_back({model_rf[instr.rs1], model_rf[instr.rs2]});
            stores_sent++;
          end
          pipe_pkg::OP_MUL: begin
            prod = model_rf[instr.rs1] * model_rf[instr.rs2];
            model_rf[instr.rd] = prod[15:0];
          end
          default: ;
        endcase
        if (instr.op == pipe_pkg::OP_LD || instr.op == pipe_pkg::OP_ST) begin
          mem_seen <= 1'b1;
        end
      end
      // oldest store still owed to the bus
      exp_avail <= exp_q.size() != 0;
      if (exp_q.size() != 0) begin
        exp_adr <= exp_q[0][31:16];
        exp_dat <= exp_q[0][15:0];
      end
    end
  end

  assert property (@(posedge clk) $fell(reset) |-> instr_ready && !wb_cyc && !wb_stb)
    else begin
      proto_errs++;
      $display("instr_ready_o low or bus active right after reset at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (reset) !mem_seen |-> !wb_cyc)
    else begin
      proto_errs++;
      $display("bus cycle started before any memory instruction at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (reset) wb_stb == wb_cyc)
    else begin
      proto_errs++;
      $display("** Error at %0t: wb_stb_o expected %b got %b",
               $time, $sampled(wb_cyc), $sampled(wb_stb));
    end

  assert property (@(posedge clk) disable iff (reset) wb_cyc && !wb_ack |=> wb_cyc)
    else begin
      proto_errs++;
      $display("wb_cyc_o dropped without an ack at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (reset)
    wb_cyc && !wb_ack |=> {wb_we, wb_adr, wb_dat_w} == held_req)
    else begin
      proto_errs++;
      $display("** Error at %0t: {wb_we_o,wb_adr_o,wb_dat_o} expected %h got %h",
               $time, $sampled(held_req), $sampled({wb_we, wb_adr, wb_dat_w}));
    end

  // stores leave in program order, so each one matches the queue head
  assert property (@(posedge clk) disable iff (reset) st_v |-> exp_avail)
    else begin
      data_errs++;
      $display("store to %h on the bus with no store outstanding at %0t",
               $sampled(wb_adr), $time);
    end

  assert property (@(posedge clk) disable iff (reset) st_v && exp_avail |-> wb_adr == exp_adr)
    else begin
      data_errs++;
      $display("** Error at %0t: wb_adr_o expected %h got %h",
               $time, $sampled(exp_adr), $sampled(wb_adr));
    end

  assert property (@(posedge clk) disable iff (reset) st_v && exp_avail |-> wb_dat_w == exp_dat)
    else begin
      data_errs++;
      $display("** Error at %0t: wb_dat_o expected %h got %h",
               $time, $sampled(exp_dat), $sampled(wb_dat_w));
    end

  // called on a rising edge, returns on the edge that accepts
  task automatic send(input pipe_pkg::opcode_e op, input int rd, input int rs1, input int rs2);
    int waited;
    waited = 0;
    if (!hung) begin
      instr_v <= 1'b1;
      instr   <= {op, 4'(rd), 4'(rs1), 4'(rs2)};
      @(negedge clk);
      while (!instr_ready && !hung) begin
        waited++;
        if (waited > ACCEPT_TO) begin
          hung = 1'b1;
          timeouts++;
          $display("instruction %h not accepted within %0d cycles", instr, ACCEPT_TO);
        end else begin
          @(negedge clk);
        end
      end
      if (!hung) begin
        @(posedge clk);
      end
    end
  endtask

  task automatic pause();
    instr_v <= 1'b0;
    @(posedge clk);
  endtask

  task automatic run_directed();
    // dependent add chain then stores
    send(pipe_pkg::OP_ADDI, 1, 0, 5);
    send(pipe_pkg::OP_ADDI, 2, 1, 3);
    send(pipe_pkg::OP_ADD, 3, 1, 2);
    send(pipe_pkg::OP_ADD, 4, 3, 3);
    send(pipe_pkg::OP_ST, 0, 0, 4);
    send(pipe_pkg::OP_ST, 0, 1, 3);
    // load use, then waw on r1
    send(pipe_pkg::OP_LD, 5, 2, 0);
    send(pipe_pkg::OP_ADD, 6, 5, 1);
    send(pipe_pkg::OP_ST, 0, 3, 6);
    send(pipe_pkg::OP_LD, 1, 4, 0);
    send(pipe_pkg::OP_ADDI, 1, 2, 7);
    send(pipe_pkg::OP_ST, 0, 2, 1);
    // multiply then store, and back-to-back multiplies
    send(pipe_pkg::OP_MUL, 7, 3, 4);
    send(pipe_pkg::OP_ST, 0, 1, 7);
    send(pipe_pkg::OP_MUL, 8, 6, 5);
    send(pipe_pkg::OP_MUL, 9, 2, 3);
    send(pipe_pkg::OP_ST, 0, 0, 8);
    send(pipe_pkg::OP_ST, 0, 4, 9);
  endtask

  task automatic run_random();
    pipe_pkg::opcode_e op;
    for (int n = 0; n < RAND_LEN; n++) begin
      op = pipe_pkg::opcode_e'(4'($urandom % 6));
      send(op, int'($urandom % 16), int'($urandom % 16), int'($urandom % 16));
      if ($urandom % 4 == 0) begin
        pause();
      end
    end
  endtask

  task automatic drain_stores();
    int waited;
    waited = 0;
    instr_v <= 1'b0;
    @(negedge clk);
    while (exp_q.size() != 0 && waited < DRAIN_TO) begin
      waited++;
      @(negedge clk);
    end
    if (waited >= DRAIN_TO) begin
      timeouts++;
      $display("%0d stores still outstanding after %0d cycles", exp_q.size(), DRAIN_TO);
    end
    // room for a stray store to show up
    repeat (4 * pipe_pkg::MUL_CYCLES) @(negedge clk);
    assert (st_cnt == stores_sent) else begin
      data_errs++;
      $display("** Error at %0t: st_cnt_o expected %0d got %0d", $time, stores_sent, st_cnt);
    end
  endtask

  initial begin : stimulus
    void'($urandom(SEED));
    reset   = 1'b1;
    instr_v = 1'b0;
    instr   = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    run_directed();
    run_random();
    drain_stores();
    $display("errors: data %0d, protocol %0d, timeouts %0d", data_errs, proto_errs, timeouts);
    if (data_errs == 0 && proto_errs == 0 && timeouts == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* tb_wb_mem.sv */
module tb_wb_mem #(
  parameter logic [pipe_pkg::DATA_W-1:0] rd_xor_p = '0
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [pipe_pkg::DATA_W-1:0] wb_adr_i,
  input  logic [pipe_pkg::DATA_W-1:0] wb_dat_i,
  output logic [pipe_pkg::DATA_W-1:0] wb_dat_o,
  output logic                        wb_ack_o,
  output int                          st_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic                          ack_r = 1'b0;
  logic                          started_r;
  logic [1:0]                    wait_r;
  logic [2*pipe_pkg::DATA_W-1:0] st_log [$];

  // read data follows a fixed rule on the address
  assign wb_dat_o = wb_adr_i ^ rd_xor_p;
  assign wb_ack_o = ack_r;
  assign st_cnt_o = st_log.size();

  always @(posedge clk_i) begin
    if (reset_i) begin
      ack_r     <= 1'b0;
      started_r <= 1'b0;
      wait_r    <= '0;
      st_log.delete();
    end else if (ack_r) begin
      ack_r     <= 1'b0;
      started_r <= 1'b0;
      if (wb_we_i) begin
        st_log.push_back({wb_adr_i, wb_dat_i});
      end
    end else if (wb_cyc_i && wb_stb_i) begin
      if (!started_r) begin
        // 0 to 3 wait states per cycle
        started_r <= 1'b1;
        wait_r    <= 2'($urandom % 4);
      end else if (wait_r == 2'd0) begin
        ack_r <= 1'b1;
      end else begin
        wait_r <= wait_r - 2'd1;
      end
    end
  end

endmodule

/* vlog.f */
pipe_pkg.sv
issue_if.sv
scoreboard.sv
regfile.sv
decode_stage.sv
execute_stage.sv
mem_unit.sv
mul_unit.sv
core_top.sv
tb_wb_mem.sv
tb_core_top.sv
